/* hdl/huff_config.svh */
`ifndef HUFF_CONFIG_SVH
`define HUFF_CONFIG_SVH

// character and count widths
`define HUFF_CHAR_W 7
`define HUFF_COUNT_W 32

// word address of table entry 0
`define HUFF_TABLE_BASE 30'h0000_0100

// end-of-file marker, never counted
`define HUFF_EOF_CHAR 7'h1A

`endif

/* hdl/huff_front_top.sv */
`timescale 1ns/1ps

module huff_front_top
  import huff_pkg::*;
(
  input  logic        hwclk,
  input  logic        rst_i,
  input  logic        cont_en_i,
  input  logic        read_in_pulse_i,
  input  char_t       in_i,
  output logic        busy_o,
  output count_t      total_o,
  output logic        finished_o,
  output char_t       least1_idx_o,
  output count_t      least1_cnt_o,
  output char_t       least2_idx_o,
  output count_t      least2_cnt_o,
  output logic        wbs_cyc_o,
  output logic        wbs_stb_o,
  output logic        wbs_we_o,
  output logic [31:0] wbs_adr_o,
  output logic [31:0] wbs_dat_o,
  input  logic [31:0] wbs_dat_i,
  input  logic        wbs_ack_i
);

  logic hist_done;

  mem_bus_if hist_bus ();
  mem_bus_if scan_bus ();
  mem_bus_if mem_bus ();

  huff_histogram i_hist (
    .hwclk       (hwclk),
    .rst_i       (rst_i),
    .cont_en_i   (cont_en_i),
    .pulse_i     (read_in_pulse_i),
    .char_i      (in_i),
    .bus         (hist_bus.client),
    .busy_o      (busy_o),
    .total_o     (total_o),
    .hist_done_o (hist_done)
  );

  // end of file starts the scan
  huff_least_finder i_finder (
    .hwclk        (hwclk),
    .rst_i        (rst_i),
    .cont_en_i    (cont_en_i),
    .start_i      (hist_done),
    .bus          (scan_bus.client),
    .finished_o   (finished_o),
    .least1_idx_o (least1_idx_o),
    .least1_cnt_o (least1_cnt_o),
    .least2_idx_o (least2_idx_o),
    .least2_cnt_o (least2_cnt_o)
  );

  sram_arbiter i_arbiter (
    .hwclk    (hwclk),
    .rst_i    (rst_i),
    .hist_bus (hist_bus.server),
    .scan_bus (scan_bus.server),
    .mem_bus  (mem_bus.client)
  );

  wishbone_manager i_manager (
    .hwclk     (hwclk),
    .rst_i     (rst_i),
    .bus       (mem_bus.server),
    .wbs_cyc_o (wbs_cyc_o),
    .wbs_stb_o (wbs_stb_o),
    .wbs_we_o  (wbs_we_o),
    .wbs_adr_o (wbs_adr_o),
    .wbs_dat_o (wbs_dat_o),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_i (wbs_ack_i)
  );

endmodule

/* hdl/huff_histogram.sv */
`timescale 1ns/1ps
`include "huff_config.svh"

module huff_histogram
  import huff_pkg::*;
(
  input  logic             hwclk,
  input  logic             rst_i,
  input  logic             cont_en_i,
  input  logic             pulse_i,
  input  char_t            char_i,
  mem_bus_if.client        bus,
  output logic             busy_o,
  output count_t           total_o,
  output logic             hist_done_o
);

  hist_state_e state_q;
  char_t       idx_q;
  count_t      cnt_q;
  count_t      total_q;
  logic        req_q;
  logic        busy_q;
  logic        done_q;

  always_ff @(posedge hwclk) begin
    if (rst_i) begin
      state_q <= HIST_IDLE;
      req_q   <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        HIST_IDLE, HIST_WAIT: begin
          if (cont_en_i) begin
            state_q <= HIST_CLEAR;
            busy_q  <= 1'b1;
            idx_q   <= '0;
            total_q <= '0;
          end else if (pulse_i && state_q == HIST_WAIT) begin
            busy_q <= 1'b1;
            if (char_i == `HUFF_EOF_CHAR) begin
              // busy stays high until the next run
              done_q  <= 1'b1;
              state_q <= HIST_IDLE;
            end else begin
              idx_q   <= char_i;
              state_q <= HIST_READ;
            end
          end
        end
        HIST_CLEAR: begin
          if (bus.done) begin
            req_q <= 1'b0;
            if (&idx_q) begin
              state_q <= HIST_WAIT;
              busy_q  <= 1'b0;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end else begin
            req_q <= 1'b1;
          end
        end
        HIST_READ: begin
          if (bus.done) begin
            req_q   <= 1'b0;
            cnt_q   <= bus.rdata;
            state_q <= HIST_WRITE;
          end else begin
            req_q <= 1'b1;
          end
        end
        HIST_WRITE: begin
          if (bus.done) begin
            req_q   <= 1'b0;
            busy_q  <= 1'b0;
            total_q <= total_q + 1'b1;
            state_q <= HIST_WAIT;
          end else begin
            req_q <= 1'b1;
          end
        end
        default: state_q <= HIST_IDLE;
      endcase
    end
  end

  // clear and write-back are the only writes
  assign bus.req   = req_q;
  assign bus.we    = (state_q == HIST_CLEAR) || (state_q == HIST_WRITE);
  assign bus.addr  = `HUFF_TABLE_BASE + word_addr_t'(idx_q);
  assign bus.wdata = (state_q == HIST_WRITE) ? cnt_q + count_t'(1) : '0;

  assign busy_o      = busy_q;
  assign total_o     = total_q;
  assign hist_done_o = done_q;

endmodule

/* hdl/huff_least_finder.sv */
`timescale 1ns/1ps
`include "huff_config.svh"

module huff_least_finder
  import huff_pkg::*;
(
  input  logic             hwclk,
  input  logic             rst_i,
  input  logic             cont_en_i,
  input  logic             start_i,
  mem_bus_if.client        bus,
  output logic             finished_o,
  output char_t            least1_idx_o,
  output count_t           least1_cnt_o,
  output char_t            least2_idx_o,
  output count_t           least2_cnt_o
);

  scan_state_e state_q;
  char_t       idx_q;
  count_t      val_q;
  logic        req_q;
  char_t       l1_idx_q;
  char_t       l2_idx_q;
  count_t      l1_cnt_q;
  count_t      l2_cnt_q;

  always_ff @(posedge hwclk) begin
    if (rst_i) begin
      state_q <= SCAN_IDLE;
      req_q   <= 1'b0;
    end else begin
      case (state_q)
        SCAN_IDLE: begin
          if (start_i) begin
            idx_q    <= '0;
            l1_idx_q <= '0;
            l1_cnt_q <= '0;
            l2_idx_q <= '0;
            l2_cnt_q <= '0;
            state_q  <= SCAN_READ;
          end
        end
        SCAN_READ: begin
          if (bus.done) begin
            req_q   <= 1'b0;
            val_q   <= bus.rdata;
            state_q <= SCAN_COMPARE;
          end else begin
            req_q <= 1'b1;
          end
        end
        SCAN_COMPARE: begin
          // a zero count marks an empty slot; strict compare keeps lower index on ties
          if (val_q != '0) begin
            if (l1_cnt_q == '0 || val_q < l1_cnt_q) begin
              l2_idx_q <= l1_idx_q;
              l2_cnt_q <= l1_cnt_q;
              l1_idx_q <= idx_q;
              l1_cnt_q <= val_q;
            end else if (l2_cnt_q == '0 || val_q < l2_cnt_q) begin
              l2_idx_q <= idx_q;
              l2_cnt_q <= val_q;
            end
          end
          if (&idx_q) begin
            state_q <= SCAN_DONE;
          end else begin
            idx_q   <= idx_q + 1'b1;
            state_q <= SCAN_READ;
          end
        end
        SCAN_DONE: begin
          if (cont_en_i) begin
            state_q <= SCAN_IDLE;
          end
        end
        default: state_q <= SCAN_IDLE;
      endcase
    end
  end

  // read-only client
  assign bus.req   = req_q;
  assign bus.we    = 1'b0;
  assign bus.addr  = `HUFF_TABLE_BASE + word_addr_t'(idx_q);
  assign bus.wdata = '0;

  assign finished_o   = (state_q == SCAN_DONE);
  assign least1_idx_o = l1_idx_q;
  assign least1_cnt_o = l1_cnt_q;
  assign least2_idx_o = l2_idx_q;
  assign least2_cnt_o = l2_cnt_q;

endmodule

/* hdl/huff_pkg.sv */
package huff_pkg;

  `include "huff_config.svh"

  typedef logic [`HUFF_CHAR_W-1:0] char_t;
  typedef logic [`HUFF_COUNT_W-1:0] count_t;
  typedef logic [29:0] word_addr_t;

  // histogram sequencing
  typedef enum logic [2:0] {
    HIST_IDLE,
    HIST_CLEAR,
    HIST_WAIT,
    HIST_READ,
    HIST_WRITE
  } hist_state_e;

  // table scan sequencing
  typedef enum logic [1:0] {
    SCAN_IDLE,
    SCAN_READ,
    SCAN_COMPARE,
    SCAN_DONE
  } scan_state_e;

endpackage

/* hdl/mem_bus_if.sv */
`timescale 1ns/1ps

// one word-wide memory client path
interface mem_bus_if;

  logic        req;
  logic        we;
  logic [29:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  // one-cycle strobe, rdata valid with it
  logic        done;

  modport client (
    output req, we, addr, wdata,
    input  rdata, done
  );

  modport server (
    input  req, we, addr, wdata,
    output rdata, done
  );

endinterface

/* hdl/sram_arbiter.sv */
`timescale 1ns/1ps

module sram_arbiter
  import huff_pkg::*;
(
  input  logic      hwclk,
  input  logic      rst_i,
  mem_bus_if.server hist_bus,
  mem_bus_if.server scan_bus,
  mem_bus_if.client mem_bus
);

  logic       lock_q;
  // high when the finder owns the path
  logic       grant_q;
  logic       sel_scan;
  word_addr_t sel_addr;

  // histogram has priority while unlocked
  always_comb begin
    if (lock_q) begin
      sel_scan = grant_q;
    end else begin
      sel_scan = !hist_bus.req && scan_bus.req;
    end
  end

  assign sel_addr      = sel_scan ? scan_bus.addr : hist_bus.addr;
  assign mem_bus.req   = sel_scan ? scan_bus.req : hist_bus.req;
  assign mem_bus.we    = sel_scan ? scan_bus.we : hist_bus.we;
  assign mem_bus.addr  = sel_addr;
  assign mem_bus.wdata = sel_scan ? scan_bus.wdata : hist_bus.wdata;

  // completion goes only to the owner
  assign hist_bus.done  = mem_bus.done && !sel_scan;
  assign scan_bus.done  = mem_bus.done && sel_scan;
  assign hist_bus.rdata = sel_scan ? '0 : mem_bus.rdata;
  assign scan_bus.rdata = sel_scan ? mem_bus.rdata : '0;

  always_ff @(posedge hwclk) begin
    if (rst_i) begin
      lock_q  <= 1'b0;
      grant_q <= 1'b0;
    end else if (!lock_q && mem_bus.req) begin
      lock_q  <= 1'b1;
      grant_q <= sel_scan;
    end else if (lock_q && mem_bus.done) begin
      lock_q <= 1'b0;
    end
  end

endmodule

/* hdl/wishbone_manager.sv */
`timescale 1ns/1ps

module wishbone_manager
  import huff_pkg::*;
(
  input  logic        hwclk,
  input  logic        rst_i,
  mem_bus_if.server   bus,
  output logic        wbs_cyc_o,
  output logic        wbs_stb_o,
  output logic        wbs_we_o,
  output logic [31:0] wbs_adr_o,
  output logic [31:0] wbs_dat_o,
  input  logic [31:0] wbs_dat_i,
  input  logic        wbs_ack_i
);

  logic        active_q;
  logic        we_q;
  logic        done_q;
  word_addr_t  addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;

  always_ff @(posedge hwclk) begin
    if (rst_i) begin
      active_q <= 1'b0;
      we_q     <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!active_q) begin
        // req is still up during the done cycle, skip it
        if (bus.req && !done_q) begin
          active_q <= 1'b1;
          we_q     <= bus.we;
          addr_q   <= bus.addr;
          wdata_q  <= bus.wdata;
        end
      end else if (wbs_ack_i) begin
        active_q <= 1'b0;
        we_q     <= 1'b0;
        done_q   <= 1'b1;
        rdata_q  <= wbs_dat_i;
      end
    end
  end

  // classic cycle, stb follows cyc
  assign wbs_cyc_o = active_q;
  assign wbs_stb_o = active_q;
  assign wbs_we_o  = we_q;
  // word to byte address
  assign wbs_adr_o = {addr_q, 2'b00};
  assign wbs_dat_o = wdata_q;

  assign bus.rdata = rdata_q;
  assign bus.done  = done_q;

endmodule

/* huff_front.f */
+incdir+hdl
hdl/huff_pkg.sv
hdl/mem_bus_if.sv
hdl/huff_histogram.sv
hdl/huff_least_finder.sv
hdl/sram_arbiter.sv
hdl/wishbone_manager.sv
hdl/huff_front_top.sv
verif/huff_front_assertions.sv
verif/huff_front_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module huff_front_tb \
  -f huff_front.f \
  -o huff_front_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/huff_front_sim)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* verif/huff_front_assertions.sv */
`timescale 1ns/1ps

module huff_front_assertions (
  input logic        hwclk,
  input logic        rst_i,
  input logic        cyc_i,
  input logic        stb_i,
  input logic        we_i,
  input logic [31:0] adr_i,
  input logic        ack_i,
  input logic        busy_i,
  input logic        finished_i
);

  // strobe stays inside the bus cycle until the slave acks
  stb_in_cycle: assert property (@(posedge hwclk) disable iff (rst_i)
    stb_i && !ack_i |=> stb_i && cyc_i)
    else $error("wishbone stb or cyc dropped before ack");

  // request fields held while the slave stalls
  req_stable: assert property (@(posedge hwclk) disable iff (rst_i)
    stb_i && !ack_i |=> $stable(adr_i) && $stable(we_i))
    else $error("wishbone address or we changed before ack");

  reset_idle: assert property (@(posedge hwclk) rst_i |=> !busy_i && !finished_i)
    else $error("busy or finished high after reset");

endmodule

bind huff_front_top huff_front_assertions i_assertions (
  .hwclk      (hwclk),
  .rst_i      (rst_i),
  .cyc_i      (wbs_cyc_o),
  .stb_i      (wbs_stb_o),
  .we_i       (wbs_we_o),
  .adr_i      (wbs_adr_o),
  .ack_i      (wbs_ack_i),
  .busy_i     (busy_o),
  .finished_i (finished_o)
);

/* verif/huff_front_tb.sv */
`timescale 1ns/1ps
`include "huff_config.svh"

module huff_front_tb
  import huff_pkg::*;
();

  localparam int    max_cycles = 20000;
  // never sent as a real character, used for ignored pulses
  localparam char_t ghost_char = 7'h7F;

  logic        hwclk = 1'b0;
  logic        rst_i;
  logic        cont_en_i;
  logic        read_in_pulse_i;
  char_t       in_i;
  logic        busy_o;
  count_t      total_o;
  logic        finished_o;
  char_t       least1_idx_o;
  count_t      least1_cnt_o;
  char_t       least2_idx_o;
  count_t      least2_cnt_o;
  logic        wbs_cyc_o;
  logic        wbs_stb_o;
  logic        wbs_we_o;
  logic [31:0] wbs_adr_o;
  logic [31:0] wbs_dat_o;
  logic [31:0] wbs_dat_i;
  logic        wbs_ack_i;

  logic [31:0] sram [0:511];
  int          ref_cnt [0:127];
  int          ref_total;
  int          ack_wait;
  bit          ack_pending;
  bit          slow_ack;
  int          cycles = 0;
  int          err_count;
  int          test_mark;
  int          tests_done;
  int          tests_failed;
  int          extra_pulses;

  huff_front_top i_dut (.*);

  always #10 hwclk = ~hwclk;

  always @(posedge hwclk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [8:0] table_slot(input int idx);
    word_addr_t wa;
    wa = `HUFF_TABLE_BASE + word_addr_t'(idx);
    return wa[8:0];
  endfunction

  // one clock, then the sram slave reacts to the bus
  task automatic step();
    word_addr_t waddr;
    @(posedge hwclk);
    #1;
    if (wbs_ack_i) begin
      wbs_ack_i = 1'b0;
    end else if (wbs_cyc_o && wbs_stb_o) begin
      if (!ack_pending) begin
        ack_pending = 1'b1;
        ack_wait = slow_ack ? 7 : int'($urandom % 8);
      end
      if (ack_wait == 0) begin
        waddr = wbs_adr_o[31:2];
        if (waddr < `HUFF_TABLE_BASE || waddr >= `HUFF_TABLE_BASE + 30'd128) begin
          $display("bus error: access outside the table at byte address %h", wbs_adr_o);
          err_count++;
        end
        if (wbs_we_o) begin
          sram[waddr[8:0]] = wbs_dat_o;
        end else begin
          wbs_dat_i = sram[waddr[8:0]];
        end
        wbs_ack_i = 1'b1;
        ack_pending = 1'b0;
      end else begin
        ack_wait--;
      end
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s: expected %0d, actual %0d", what, expected, actual);
    err_count++;
  endtask

  task automatic close_test(input string name);
    tests_done++;
    if (err_count == test_mark) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_count - test_mark);
    end
    test_mark = err_count;
  endtask

  // cont_en pulse, then wait out the table clear
  task automatic start_run();
    for (int i = 0; i < 128; i++) begin
      ref_cnt[7'(i)] = 0;
    end
    ref_total = 0;
    cont_en_i = 1'b1;
    step();
    cont_en_i = 1'b0;
    while (busy_o) step();
  endtask

  task automatic send_char(input char_t c, input bit with_extra);
    while (busy_o) step();
    read_in_pulse_i = 1'b1;
    in_i = c;
    step();
    read_in_pulse_i = 1'b0;
    ref_cnt[c]++;
    ref_total++;
    // pulses during the busy window must be dropped
    while (with_extra && busy_o) begin
      read_in_pulse_i = 1'b1;
      in_i = ghost_char;
      extra_pulses++;
      step();
      read_in_pulse_i = 1'b0;
    end
  endtask

  task automatic end_stream();
    while (busy_o) step();
    read_in_pulse_i = 1'b1;
    in_i = `HUFF_EOF_CHAR;
    step();
    read_in_pulse_i = 1'b0;
    while (!finished_o) step();
  endtask

  // mostly a narrow band so that equal counts show up
  function automatic char_t pick_char();
    char_t c;
    c = `HUFF_EOF_CHAR;
    while (c == `HUFF_EOF_CHAR || c == ghost_char) begin
      if ($urandom % 4 != 0) begin
        c = 7'h40 + char_t'($urandom % 16);
      end else begin
        c = char_t'($urandom % 128);
      end
    end
    return c;
  endfunction

  task automatic check_table(input string name);
    logic [31:0] got;
    for (int i = 0; i < 128; i++) begin
      got = sram[table_slot(i)];
      if (got !== 32'(ref_cnt[7'(i)])) begin
        report_mismatch($sformatf("%s entry %0d", name, i), 32'(ref_cnt[7'(i)]), got);
      end
    end
  endtask

  // smallest non-zero count first, then the next one; lower index wins ties
  task automatic check_least(input string name);
    int          i1;
    int          i2;
    logic [31:0] exp_idx;
    logic [31:0] exp_cnt;
    i1 = -1;
    i2 = -1;
    for (int i = 0; i < 128; i++) begin
      if (ref_cnt[7'(i)] != 0 && (i1 < 0 || ref_cnt[7'(i)] < ref_cnt[7'(i1)])) i1 = i;
    end
    for (int i = 0; i < 128; i++) begin
      if (i != i1 && ref_cnt[7'(i)] != 0 && (i2 < 0 || ref_cnt[7'(i)] < ref_cnt[7'(i2)])) i2 = i;
    end
    exp_idx = (i1 < 0) ? 32'd0 : 32'(i1);
    exp_cnt = (i1 < 0) ? 32'd0 : 32'(ref_cnt[7'(i1)]);
    if (32'(least1_idx_o) !== exp_idx) begin
      report_mismatch({name, " least1 index"}, exp_idx, 32'(least1_idx_o));
    end
    if (least1_cnt_o !== exp_cnt) begin
      report_mismatch({name, " least1 count"}, exp_cnt, least1_cnt_o);
    end
    exp_idx = (i2 < 0) ? 32'd0 : 32'(i2);
    exp_cnt = (i2 < 0) ? 32'd0 : 32'(ref_cnt[7'(i2)]);
    if (32'(least2_idx_o) !== exp_idx) begin
      report_mismatch({name, " least2 index"}, exp_idx, 32'(least2_idx_o));
    end
    if (least2_cnt_o !== exp_cnt) begin
      report_mismatch({name, " least2 count"}, exp_cnt, least2_cnt_o);
    end
  endtask

  initial begin
    void'($urandom(17));
    rst_i = 1'b1;
    cont_en_i = 1'b0;
    read_in_pulse_i = 1'b0;
    in_i = '0;
    wbs_dat_i = '0;
    wbs_ack_i = 1'b0;
    ack_pending = 1'b0;
    ack_wait = 0;
    slow_ack = 1'b0;
    err_count = 0;
    test_mark = 0;
    tests_done = 0;
    tests_failed = 0;
    extra_pulses = 0;
    repeat (4) step();
    rst_i = 1'b0;

    // stale table contents must be wiped by the clear
    for (int a = 0; a < 512; a++) begin
      sram[9'(a)] = $urandom;
    end
    start_run();
    end_stream();
    check_table("clear_empty");
    check_least("clear_empty");
    if (total_o !== 32'd0) begin
      report_mismatch("clear_empty total", 32'd0, total_o);
    end
    close_test("clear_empty");

    start_run();
    for (int n = 0; n < 64; n++) begin
      send_char(pick_char(), 1'b0);
    end
    end_stream();
    check_table("random_counts");
    close_test("random_counts");
    check_least("least_pair");
    close_test("least_pair");
    if (total_o !== 32'(ref_total)) begin
      report_mismatch("total", 32'(ref_total), total_o);
    end
    close_test("total");

    // third run, first part under slow acks with extra pulses
    start_run();
    slow_ack = 1'b1;
    for (int n = 0; n < 8; n++) begin
      send_char(pick_char(), 1'b1);
    end
    slow_ack = 1'b0;
    for (int n = 8; n < 64; n++) begin
      send_char(pick_char(), 1'b0);
    end
    end_stream();
    if (extra_pulses == 0) begin
      $display("ignored_pulses: no extra pulse was issued while busy was high");
      err_count++;
    end
    if (sram[table_slot(int'(ghost_char))] !== 32'd0) begin
      report_mismatch("ignored_pulses ghost count", 32'd0, sram[table_slot(int'(ghost_char))]);
    end
    if (total_o !== 32'(ref_total)) begin
      report_mismatch("ignored_pulses total", 32'(ref_total), total_o);
    end
    close_test("ignored_pulses");
    check_table("restart");
    check_least("restart");
    close_test("restart");

    $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             tests_done, tests_done - tests_failed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
